// ==== list.f ====
+incdir+verilog
verilog/vcu_pkg.sv
verilog/vcu_issue_if.sv
verilog/vcu_issue_ctrl.sv
verilog/vcu_config_regs.sv
verilog/vcu_op_decoder.sv
verilog/vcu_hazard_tracker.sv
verilog/vcu_top.sv
verif/vcu_tb.sv

// ==== verif/vcu_tb.sv ====
// vector control unit testbench
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_tb;

   localparam int NUM_TESTS = 11;
   localparam int LIMIT     = 2 * NUM_TESTS + 40; // cycles before giving up

   typedef struct packed {
      logic [`VCU_CLASSES-1:0] cls;
      logic [31:0]             instr;
      logic [31:0]             rs1;
      logic [`VCU_PORTS-1:0]   ports;     // ready groups at drive time
      logic [3:0]              hold;      // edges before late ports, 0 for none
      logic [`VCU_PORTS-1:0]   late;
      logic                    dep;       // waits on the previous destination
      logic [2:0]              exp_type;
      logic [1:0]              exp_op2;
      logic [5:0]              exp_alu;
      logic [`VCU_PORTS-1:0]   exp_start;
      logic [3:0]              exp_lat;   // edges from acceptance to start
      logic [2:0]              exp_sew;
      logic [2:0]              exp_lmul;
      logic [31:0]             exp_vl;
      logic [31:0]             exp_slide; // only for slides
      logic                    exp_dir;   // low for slidedown
      logic                    exp_mask;
      logic [1:0]              exp_width; // at the sew in force when decoded
      logic [4:0]              exp_imm;
   } test_t;

   logic                    clk;
   logic                    rstn;
   logic [`VCU_CLASSES-1:0] instr_vld_i;
   logic [31:0]             vector_instr_i;
   logic [31:0]             scalar_rs1_i;
   logic [`VCU_PORTS-1:0]   port_group_ready_i;
   logic                    instr_rdy_o;
   logic [`VCU_PORTS-1:0]   start_o;
   logic [2:0]              sew_o, lmul_o, inst_type_o;
   logic [31:0]             vl_o, alu_x_data_o, slide_amount_o;
   logic [1:0]              op2_sel_o, wdata_width_o;
   logic [5:0]              alu_opmode_o;
   logic [4:0]              alu_imm_o;
   logic                    up_down_slide_o, reduction_op_o, vector_mask_o;

   test_t       tests [NUM_TESTS];
   string       names [NUM_TESTS];
   int          cyc = 0;     // rising edges so far
   int          last_issue;  // edge at which the last word left on a port
   logic [31:0] cur_vl;      // vl before the next config update
   int          seed;

   vcu_top u_vcu_top (
      .clk(clk), .rstn(rstn), .instr_vld_i(instr_vld_i), .vector_instr_i(vector_instr_i),
      .scalar_rs1_i(scalar_rs1_i), .port_group_ready_i(port_group_ready_i),
      .instr_rdy_o(instr_rdy_o), .start_o(start_o), .sew_o(sew_o), .lmul_o(lmul_o),
      .vl_o(vl_o), .inst_type_o(inst_type_o), .op2_sel_o(op2_sel_o),
      .alu_opmode_o(alu_opmode_o), .alu_x_data_o(alu_x_data_o), .alu_imm_o(alu_imm_o),
      .slide_amount_o(slide_amount_o), .up_down_slide_o(up_down_slide_o),
      .reduction_op_o(reduction_op_o), .wdata_width_o(wdata_width_o),
      .vector_mask_o(vector_mask_o)
   );

   always #10 clk = ~clk; // 20 ns period

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (cyc >= LIMIT)
      begin
         $display("timeout after %0d cycles, the table never completed", cyc);
         $display("STATUS: FAIL");
         $fatal(1, "timeout");
      end
   end

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("[ERROR] %s expected %0d actual %0d", what, exp, act);
         $display("STATUS: FAIL");
         $fatal(1, "mismatch in %s", what);
      end
   endtask

   function automatic logic [`VCU_CLASSES-1:0] class_onehot(input int b);
      class_onehot = `VCU_CLASSES'(1) << b;
   endfunction

   // unmasked arithmetic word, opcode OP-V
   function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [4:0] vs2,
                                              input logic [4:0] vs1, input logic [2:0] f3,
                                              input logic [4:0] vd);
      arith_word = {f6, 1'b1, vs2, vs1, f3, vd, 7'h57};
   endfunction

   // sel 10 takes vtype from rs1
   function automatic logic [31:0] cfg_word(input logic [1:0] sel, input logic [2:0] lmul,
                                            input logic [2:0] sew, input logic [4:0] rs1_idx,
                                            input logic [4:0] rd);
      cfg_word = {sel, 4'b0000, lmul[2], sew, lmul[1:0], rs1_idx, 3'b111, rd, 7'h57};
   endfunction

   task automatic add_test(input int i, input string n, input logic [11:0] cls,
                           input logic [31:0] instr, input logic [31:0] rs1,
                           input logic [3:0] ports, input logic [3:0] hold,
                           input logic [3:0] late, input logic dep, input logic [2:0] typ,
                           input logic [1:0] op2, input logic [5:0] alu,
                           input logic [3:0] start, input logic [3:0] lat,
                           input logic [2:0] sew, input logic [2:0] lmul,
                           input logic [31:0] vl, input logic [31:0] slide,
                           input logic dir, input logic mask, input logic [1:0] width,
                           input logic [4:0] imm);
      names[i] = n;
      tests[i] = '{cls, instr, rs1, ports, hold, late, dep, typ, op2, alu, start, lat,
                   sew, lmul, vl, slide, dir, mask, width, imm};
   endtask

   task automatic run_test(input int i);
      test_t t;
      int    lat;
      t = tests[i];
      @(posedge clk);
      #2;
      instr_vld_i        = t.cls;
      vector_instr_i     = t.instr;
      scalar_rs1_i       = t.rs1;
      port_group_ready_i = t.ports;
      #3;
      while (!instr_rdy_o) // previous word still held
      begin
         @(posedge clk);
         #5;
      end
      @(posedge clk); // acceptance edge
      #2;
      instr_vld_i = '0;
      #3;
      check({names[i], " type"}, t.exp_type, inst_type_o);
      check({names[i], " op2 select"}, t.exp_op2, op2_sel_o);
      check({names[i], " alu opmode"}, t.exp_alu, alu_opmode_o);
      check({names[i], " scalar data"}, t.rs1, alu_x_data_o);
      check({names[i], " reduction"}, t.exp_type == 3'd1, reduction_op_o);
      check({names[i], " slide dir"}, t.exp_dir, up_down_slide_o);
      check({names[i], " mask enable"}, t.exp_mask, vector_mask_o);
      check({names[i], " write width"}, t.exp_width, wdata_width_o);
      check({names[i], " immediate"}, t.exp_imm, alu_imm_o);
      if (t.exp_type == 3'd6)
         check({names[i], " slide amount"}, t.exp_slide, slide_amount_o);
      if (t.cls[`VCU_CLS_CFG])
      begin
         check({names[i], " cfg start"}, 0, start_o);
         check({names[i], " vl before update"}, cur_vl, vl_o);
         @(posedge clk); // state update edge
         #5;
      end
      else
      begin
         lat = 0;
         while (start_o == '0)
         begin
            check({names[i], " stall ready"}, 0, instr_rdy_o);
            @(posedge clk);
            lat++;
            #2;
            if (lat == t.hold)
               port_group_ready_i = t.late; // a group frees up
            #3;
         end
         check({names[i], " start"}, t.exp_start, start_o);
         check({names[i], " ready at issue"}, 1, instr_rdy_o);
         if (t.dep)
            check({names[i], " hazard release"}, `VCU_DEP_DELAY, cyc - last_issue);
         else
            check({names[i], " latency"}, t.exp_lat, lat);
         last_issue = cyc + 1; // leaves at the coming edge
      end
      check({names[i], " sew"}, t.exp_sew, sew_o);
      check({names[i], " lmul"}, t.exp_lmul, lmul_o);
      check({names[i], " vl"}, t.exp_vl, vl_o);
      cur_vl = t.exp_vl;
   endtask

   initial
   begin
      seed = 34;
      void'($urandom(seed));
      clk                = 1'b0;
      rstn               = 1'b0;
      instr_vld_i        = '0;
      vector_instr_i     = '0;
      scalar_rs1_i       = '0;
      port_group_ready_i = '0;
      last_issue         = 0;
      // vsetvli e16 m2 with rd set, vl becomes vlmax
      add_test(0, "vsetvli", class_onehot(`VCU_CLS_CFG), cfg_word(2'b00, 3'd1, 3'd1, 5'd0, 5'd1),
               $urandom, 4'hf, 0, 0, 0, 7, 3, 0, 0, 0, 1, 1, 512, 0, 1, 1, 3, 0);
      // vtype e32 m1 packed in rs1, vl taken from rs1
      add_test(1, "vsetvl", class_onehot(`VCU_CLS_CFG), cfg_word(2'b10, 3'd0, 3'd0, 5'd5, 5'd1),
               32'h10, 4'hf, 0, 0, 0, 7, 3, 0, 0, 0, 2, 0, 16, 0, 1, 1, 2, 5);
      add_test(2, "vadd.vv", class_onehot(`VCU_CLS_OPIVV), arith_word(6'o00, 2, 3, 3'b000, 4),
               $urandom, 4'hf, 0, 0, 0, 0, 0, 1, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 3);
      add_test(3, "vsub.vx", class_onehot(`VCU_CLS_OPIVX), arith_word(6'o02, 5, 6, 3'b100, 7),
               $urandom, 4'hf, 0, 0, 0, 0, 1, 3, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 6);
      add_test(4, "vmul.vv", class_onehot(`VCU_CLS_OPMVV), arith_word(6'o45, 8, 9, 3'b010, 10),
               $urandom, 4'hf, 0, 0, 0, 0, 0, 19, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 9);
      add_test(5, "load", class_onehot(`VCU_CLS_LOAD), arith_word(6'o00, 12, 11, 3'b110, 13),
               $urandom, 4'hf, 0, 0, 0, 4, 3, 0, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 11);
      // lowest ready group wins
      add_test(6, "port pick", class_onehot(`VCU_CLS_OPIVV), arith_word(6'o11, 14, 15, 0, 16),
               $urandom, 4'b0110, 0, 0, 0, 0, 0, 5, 4'b0010, 0, 2, 0, 16, 0, 1, 0, 3, 15);
      add_test(7, "port wait", class_onehot(`VCU_CLS_OPIVV), arith_word(6'o13, 17, 18, 0, 19),
               $urandom, 4'b0000, 3, 4'hf, 0, 0, 0, 7, 4'b0001, 3, 2, 0, 16, 0, 1, 0, 3, 18);
      // producer then a consumer of v22
      add_test(8, "raw source", class_onehot(`VCU_CLS_OPIVV), arith_word(6'o12, 20, 21, 0, 22),
               $urandom, 4'hf, 0, 0, 0, 0, 0, 6, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 21);
      add_test(9, "raw consumer", class_onehot(`VCU_CLS_OPIVV), arith_word(6'o00, 23, 22, 0, 24),
               $urandom, 4'hf, 0, 0, 1, 0, 0, 1, 4'b0001, 0, 2, 0, 16, 0, 1, 0, 3, 22);
      add_test(10, "vslidedown.vi", class_onehot(`VCU_CLS_OPIVI), arith_word(6'o17, 25, 3, 3, 26),
               $urandom, 4'hf, 0, 0, 0, 6, 2, 0, 4'b0001, 0, 2, 0, 16, 12, 0, 0, 3, 3);
      repeat (5) @(posedge clk);
      #2;
      rstn = 1'b1;
      #3;
      check("reset ready", 1, instr_rdy_o);
      check("reset start", 0, start_o);
      check("reset sew", 2, sew_o);
      check("reset lmul", 0, lmul_o);
      check("reset vl", 128, vl_o);
      check("reset type", 7, inst_type_o); // empty register
      check("reset reduction", 0, reduction_op_o);
      cur_vl = 128;
      for (int i = 0; i < NUM_TESTS; i++)
         run_test(i);
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/vcu_top.sv ====
// vector control unit top
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_top (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic [`VCU_CLASSES-1:0] instr_vld_i,
   input  wire logic [31:0]             vector_instr_i,
   input  wire logic [31:0]             scalar_rs1_i,
   input  wire logic [`VCU_PORTS-1:0]   port_group_ready_i,
   output logic                         instr_rdy_o,
   output logic [`VCU_PORTS-1:0]        start_o,
   output logic [2:0]                   sew_o,
   output logic [2:0]                   lmul_o,
   output logic [31:0]                  vl_o,
   output logic [2:0]                   inst_type_o,
   output logic [1:0]                   op2_sel_o,
   output logic [5:0]                   alu_opmode_o,
   output logic [31:0]                  alu_x_data_o,
   output logic [4:0]                   alu_imm_o,
   output logic [31:0]                  slide_amount_o,
   output logic                         up_down_slide_o,
   output logic                         reduction_op_o,
   output logic [1:0]                   wdata_width_o,
   output logic                         vector_mask_o
);

   logic hazard; // tracker back to issue control

   vcu_issue_if bus (.clk(clk));

   vcu_issue_ctrl u_issue_ctrl (
      .clk(clk), .rstn(rstn),
      .instr_vld_i(instr_vld_i), .vector_instr_i(vector_instr_i),
      .scalar_rs1_i(scalar_rs1_i), .port_group_ready_i(port_group_ready_i),
      .hazard_i(hazard), .instr_rdy_o(instr_rdy_o), .start_o(start_o),
      .bus(bus.ctrl)
   );

   vcu_config_regs u_config_regs (
      .clk(clk), .rstn(rstn), .bus(bus.dp),
      .sew_o(sew_o), .lmul_o(lmul_o), .vl_o(vl_o)
   );

   vcu_op_decoder u_op_decoder (
      .bus(bus.dp), .sew_i(sew_o),
      .inst_type_o(inst_type_o), .op2_sel_o(op2_sel_o), .alu_opmode_o(alu_opmode_o),
      .slide_amount_o(slide_amount_o), .up_down_slide_o(up_down_slide_o),
      .reduction_op_o(reduction_op_o), .wdata_width_o(wdata_width_o),
      .vector_mask_o(vector_mask_o), .alu_x_data_o(alu_x_data_o), .alu_imm_o(alu_imm_o)
   );

   vcu_hazard_tracker u_hazard_tracker (
      .clk(clk), .rstn(rstn), .bus(bus.dp),
      .start_i(start_o), .hazard_o(hazard)
   );

endmodule

`default_nettype wire

// ==== verilog/vcu_hazard_tracker.sv ====
// raw hazard tracker
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_hazard_tracker (
   input  wire logic                  clk,
   input  wire logic                  rstn,
   vcu_issue_if.dp                    bus,
   input  wire logic [`VCU_PORTS-1:0] start_i,
   output logic                       hazard_o
);

   localparam int CNT_W = $clog2(`VCU_DEP_DELAY + 1);

   logic [`VCU_PORTS-1:0]            slot_vld;
   logic [`VCU_PORTS-1:0][4:0]       slot_vd;
   logic [`VCU_PORTS-1:0][CNT_W-1:0] slot_cnt;
   logic [`VCU_PORTS-1:0]            load;  // slot taken this edge
   logic [`VCU_PORTS-1:0]            match; // per slot source hit

   assign load = bus.issue ? start_i : '0;

   always_ff @(posedge clk)
   begin
      if (!rstn)
         slot_vld <= '0;
      else
         for (int i = 0; i < `VCU_PORTS; i++)
         begin
            if (load[i])
               slot_vld[i] <= 1'b1;
            else if (slot_vld[i] && slot_cnt[i] == CNT_W'(1))
               slot_vld[i] <= 1'b0; // count reaches zero, port free
         end
   end

   // vd and countdown only matter while the slot is valid
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `VCU_PORTS; i++)
      begin
         if (load[i])
         begin
            slot_vd[i]  <= bus.instr.arith.vd;
            slot_cnt[i] <= CNT_W'(`VCU_DEP_DELAY);
         end
         else if (slot_vld[i])
            slot_cnt[i] <= slot_cnt[i] - CNT_W'(1);
      end
   end

   always_comb
   begin
      for (int i = 0; i < `VCU_PORTS; i++)
         match[i] = slot_vld[i] && (slot_vd[i] == bus.instr.arith.vs1 ||
                                    slot_vd[i] == bus.instr.arith.vs2);
   end

   assign hazard_o = bus.valid && !bus.cls[`VCU_CLS_CFG] && |match;

   single_load: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(load));

endmodule

`default_nettype wire

// ==== verilog/vcu_op_decoder.sv ====
// lane control decode
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_op_decoder (
   vcu_issue_if.dp                bus,
   input  wire logic [2:0]        sew_i,
   output vcu_pkg::inst_type_e    inst_type_o,
   output logic [1:0]             op2_sel_o,
   output vcu_pkg::alu_op_e       alu_opmode_o,
   output logic [31:0]            slide_amount_o,
   output logic                   up_down_slide_o,
   output logic                   reduction_op_o,
   output logic [1:0]             wdata_width_o,
   output logic                   vector_mask_o,
   output logic [31:0]            alu_x_data_o,
   output logic [4:0]             alu_imm_o
);

   logic [5:0] funct6;
   logic       is_opi, is_opm;
   logic       is_slide, is_widen;

   assign funct6 = bus.instr.arith.funct6;
   assign is_opi = |{bus.cls[`VCU_CLS_OPIVX], bus.cls[`VCU_CLS_OPIVI], bus.cls[`VCU_CLS_OPIVV]};
   assign is_opm = bus.cls[`VCU_CLS_OPMVX] || bus.cls[`VCU_CLS_OPMVV];

   assign reduction_op_o = (is_opm && funct6[5:3] == 3'b000) ||
                           (bus.cls[`VCU_CLS_OPIVV] && funct6[5:3] == 3'b110);
   assign is_slide = bus.valid && !bus.cls[`VCU_CLS_CFG] &&
                     (funct6 == 6'b001110 || funct6 == 6'b001111);
   assign is_widen = funct6[5:4] == 2'b11;

   always_comb
   begin
      if (bus.cls[`VCU_CLS_STORE])           inst_type_o = vcu_pkg::itype_store;
      else if (bus.cls[`VCU_CLS_ISTORE])     inst_type_o = vcu_pkg::itype_istore;
      else if (bus.cls[`VCU_CLS_LOAD])       inst_type_o = vcu_pkg::itype_load;
      else if (bus.cls[`VCU_CLS_ILOAD])      inst_type_o = vcu_pkg::itype_iload;
      else if (reduction_op_o)               inst_type_o = vcu_pkg::itype_reduction;
      else if (is_slide)                     inst_type_o = vcu_pkg::itype_slide;
      else if (bus.valid && !bus.cls[`VCU_CLS_CFG])
         inst_type_o = vcu_pkg::itype_normal;
      else
         inst_type_o = vcu_pkg::itype_invalid; // empty slot or config
   end

   // operand 2 source, vv / vx / vi
   assign op2_sel_o = (bus.cls[`VCU_CLS_OPIVV] || bus.cls[`VCU_CLS_OPMVV]) ? 2'd0 :
                      (bus.cls[`VCU_CLS_OPIVX] || bus.cls[`VCU_CLS_OPMVX]) ? 2'd1 :
                      bus.cls[`VCU_CLS_OPIVI]                              ? 2'd2 : 2'd3;

   always_comb
   begin
      alu_opmode_o = vcu_pkg::nop_op; // unlisted funct6
      if (is_opi)
         case (funct6)
            6'b000000, 6'b110000: alu_opmode_o = vcu_pkg::add_op; // vadd, vwredsumu
            6'b000010, 6'b000011: alu_opmode_o = vcu_pkg::sub_op; // vsub, vrsub
            6'b001001: alu_opmode_o = vcu_pkg::and_op;
            6'b001010: alu_opmode_o = vcu_pkg::or_op;
            6'b001011: alu_opmode_o = vcu_pkg::xor_op;
            6'b011000: alu_opmode_o = vcu_pkg::seq_op;   // vmseq
            6'b011001: alu_opmode_o = vcu_pkg::sneq_op;
            6'b011010: alu_opmode_o = vcu_pkg::sltu_op;
            6'b011011: alu_opmode_o = vcu_pkg::slt_op;
            6'b011100: alu_opmode_o = vcu_pkg::sleu_op;
            6'b011101: alu_opmode_o = vcu_pkg::sle_op;
            6'b011110: alu_opmode_o = vcu_pkg::sgtu_op;
            6'b011111: alu_opmode_o = vcu_pkg::sgt_op;
            6'b100000: alu_opmode_o = vcu_pkg::addu_op;  // vsaddu
            6'b100010: alu_opmode_o = vcu_pkg::subu_op;  // vssubu
            6'b100101: alu_opmode_o = vcu_pkg::sll_op;
            6'b100111: alu_opmode_o = vcu_pkg::mul_op;   // vsmul
            6'b101000: alu_opmode_o = vcu_pkg::srl_op;
            6'b101001: alu_opmode_o = vcu_pkg::sra_op;
            default:   alu_opmode_o = vcu_pkg::nop_op;
         endcase
      else if (is_opm)
         case (funct6)
            6'b000000, 6'b110001: alu_opmode_o = vcu_pkg::add_op; // vredsum, vwadd
            6'b000001: alu_opmode_o = vcu_pkg::and_op;   // vredand
            6'b000010: alu_opmode_o = vcu_pkg::or_op;
            6'b000011: alu_opmode_o = vcu_pkg::xor_op;
            6'b001000, 6'b110000: alu_opmode_o = vcu_pkg::addu_op; // vaaddu, vwaddu
            6'b001010, 6'b110010: alu_opmode_o = vcu_pkg::subu_op;
            6'b110011: alu_opmode_o = vcu_pkg::sub_op;   // vwsub
            6'b100100: alu_opmode_o = vcu_pkg::mulhu_op;
            6'b100101: alu_opmode_o = vcu_pkg::mul_op;
            6'b100111: alu_opmode_o = vcu_pkg::mulh_op;
            6'b101001, 6'b101101: alu_opmode_o = vcu_pkg::mul_add_op; // vmadd, vmacc
            6'b101011, 6'b101111: alu_opmode_o = vcu_pkg::mul_sub_op; // vnmsub, vnmsac
            default:   alu_opmode_o = vcu_pkg::nop_op;
         endcase
   end

   // slide offset in bytes
   assign slide_amount_o = bus.cls[`VCU_CLS_OPIVI] ? {27'd0, bus.instr.arith.vs1} << sew_i :
                           bus.cls[`VCU_CLS_OPIVX] ? bus.rs1 << sew_i : 32'd1 << sew_i;
   assign up_down_slide_o = funct6 != 6'b001111; // low for slidedown

   assign wdata_width_o = is_widen ? 2'(sew_i + 3'd2) : 2'(sew_i + 3'd1);

   assign vector_mask_o = ~bus.instr.arith.vm;
   assign alu_x_data_o  = bus.rs1;
   assign alu_imm_o     = bus.instr.arith.vs1;

endmodule

`default_nettype wire

// ==== verilog/vcu_config_regs.sv ====
// vtype and vector length state
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_config_regs (
   input  wire logic  clk,
   input  wire logic  rstn,
   vcu_issue_if.dp    bus,
   output logic [2:0] sew_o,
   output logic [2:0] lmul_o,
   output logic [31:0] vl_o
);

   vcu_pkg::vtype_t vtype_q, vtype_d;
   logic [31:0]     vl_q, vl_d;
   logic [31:0]     vlmax_base; // elements at lmul 1
   logic [31:0]     vlmax;

   always_comb
   begin
      if (bus.instr.cfg.sel == 2'b10)
      begin
         // vsetvl, vtype packed in rs1 as lmul[2:0] sew[5:3] vta[6] vma[7]
         vtype_d.lmul = bus.rs1[2:0];
         vtype_d.sew  = bus.rs1[5:3];
         vtype_d.vta  = bus.rs1[6];
         vtype_d.vma  = bus.rs1[7];
      end
      else
      begin
         vtype_d.lmul = {bus.instr.cfg.lmul_hi, bus.instr.cfg.lmul_lo};
         vtype_d.sew  = bus.instr.cfg.sew;
         vtype_d.vta  = bus.instr.cfg.vta;
         vtype_d.vma  = bus.instr.cfg.vma;
      end
   end

   // vlmax = vlen/8 / 2^sew, scaled by lmul
   assign vlmax_base = 32'(`VCU_VLEN / 8) >> vtype_d.sew;

   always_comb
   begin
      if (!vtype_d.lmul[2])
         vlmax = vlmax_base << vtype_d.lmul[1:0];               // m1..m8
      else if (vtype_d.lmul != 3'd4)
         vlmax = vlmax_base >> (4'd8 - {1'b0, vtype_d.lmul});   // mf8..mf2
      else
         vlmax = vlmax_base; // reserved lmul, treat as m1
   end

   assign vl_d = (bus.instr.cfg.rs1 != 5'd0) ? bus.rs1 :
                 (bus.instr.cfg.rd != 5'd0)  ? vlmax   : vl_q;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_q <= '{sew: 3'd2, lmul: 3'd0, vta: 1'b0, vma: 1'b0}; // e32 m1
         vl_q    <= 32'(`VCU_VLEN / 32);
      end
      else if (bus.valid && bus.cls[`VCU_CLS_CFG])
      begin
         vtype_q <= vtype_d;
         vl_q    <= vl_d;
      end
   end

   assign sew_o  = vtype_q.sew;
   assign lmul_o = vtype_q.lmul;
   assign vl_o   = vl_q;

   // lanes handle e8..e32 only
   sew_supported: assert property (@(posedge clk) disable iff (!rstn)
      sew_o <= 3'd2);

endmodule

`default_nettype wire

// ==== verilog/vcu_issue_ctrl.sv ====
// instruction register and issue control
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

module vcu_issue_ctrl (
   input  wire logic                    clk,
   input  wire logic                    rstn,
   input  wire logic [`VCU_CLASSES-1:0] instr_vld_i,
   input  wire logic [31:0]             vector_instr_i,
   input  wire logic [31:0]             scalar_rs1_i,
   input  wire logic [`VCU_PORTS-1:0]   port_group_ready_i,
   input  wire logic                    hazard_i,
   output logic                         instr_rdy_o,
   output logic [`VCU_PORTS-1:0]        start_o,
   vcu_issue_if.ctrl                    bus
);

   logic                   need_port;   // non-config word waiting
   logic                   stall;
   logic [`VCU_PORTS-1:0]  lowest_rdy;  // one-hot, zero if none ready

   // class register, empty after reset
   always_ff @(posedge clk)
   begin
      if (!rstn)
         bus.cls <= '0;
      else if (instr_rdy_o)
         bus.cls <= instr_vld_i; // zero class empties the slot
   end

   // payload follows the class
   always_ff @(posedge clk)
   begin
      if (instr_rdy_o)
      begin
         bus.instr <= vector_instr_i;
         bus.rs1   <= scalar_rs1_i;
      end
   end

   assign bus.valid = |bus.cls;
   assign need_port = bus.valid && !bus.cls[`VCU_CLS_CFG]; // config words never take a port

   // isolate lowest set bit
   assign lowest_rdy = port_group_ready_i & (~port_group_ready_i + `VCU_PORTS'(1));

   assign stall       = need_port && (hazard_i || port_group_ready_i == '0);
   assign instr_rdy_o = !stall; // hold the word while it can't leave

   assign start_o   = (need_port && !hazard_i) ? lowest_rdy : '0;
   assign bus.issue = |start_o;

   start_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(start_o));

endmodule

`default_nettype wire

// ==== verilog/vcu_issue_if.sv ====
// registered instruction bus
`timescale 1ns/1ns
`default_nettype none
`include "vcu_consts.svh"

interface vcu_issue_if (input wire logic clk);

   vcu_pkg::instr_u          instr; // registered instruction word
   logic [`VCU_CLASSES-1:0]  cls;   // registered one-hot class
   logic [31:0]              rs1;   // registered scalar operand
   logic                     valid; // register not empty
   logic                     issue; // instr leaves on a port this cycle

   modport ctrl (input clk, output instr, output cls, output rs1, output valid, output issue);
   modport dp (input clk, input instr, input cls, input rs1, input valid, input issue);

   // a held word carries exactly one class
   cls_onehot: assert property (@(posedge clk)
      valid |-> $onehot(cls));

endinterface

`default_nettype wire

// ==== verilog/vcu_pkg.sv ====
// vector control unit types
`default_nettype none

package vcu_pkg;

   // one instruction word, read either as arithmetic or as vsetvl
   typedef union packed {
      struct packed {
         logic [5:0] funct6;
         logic       vm;        // 0 means masked
         logic [4:0] vs2;
         logic [4:0] vs1;       // also simm5 / uimm5
         logic [2:0] funct3;
         logic [4:0] vd;
         logic [6:0] opcode;
      } arith;
      struct packed {
         logic [1:0] sel;       // 2'b10 is vsetvl, vtype from rs1
         logic [1:0] rsvd;
         logic       vma;
         logic       vta;
         logic       lmul_hi;
         logic [2:0] sew;
         logic [1:0] lmul_lo;
         logic [4:0] rs1;
         logic [2:0] funct3;
         logic [4:0] rd;
         logic [6:0] opcode;
      } cfg;
   } instr_u;

   // alu opmodes seen by the lanes
   typedef enum logic [5:0] {
      nop_op, add_op, addu_op, sub_op, subu_op,
      and_op, or_op, xor_op,
      sll_op, srl_op, sra_op,
      seq_op, sneq_op, slt_op, sltu_op, sle_op, sleu_op, sgt_op, sgtu_op,
      mul_op, mulh_op, mulhu_op, mul_add_op, mul_sub_op
   } alu_op_e;

   typedef enum logic [2:0] {
      itype_normal    = 3'd0,
      itype_reduction = 3'd1,
      itype_store     = 3'd2,
      itype_istore    = 3'd3,
      itype_load      = 3'd4,
      itype_iload     = 3'd5,
      itype_slide     = 3'd6,
      itype_invalid   = 3'd7
   } inst_type_e;

   typedef struct packed {
      logic [2:0] sew;  // 0:e8 1:e16 2:e32
      logic [2:0] lmul; // 5..7 fractional
      logic       vta;
      logic       vma;
   } vtype_t;

endpackage

`default_nettype wire

// ==== verilog/vcu_consts.svh ====
// vector control unit constants
`ifndef VCU_CONSTS_SVH
`define VCU_CONSTS_SVH

`define VCU_VLEN       4096 // bits per vector register
`define VCU_PORTS      4    // write-port groups
`define VCU_CLASSES    12   // width of the one-hot class vector

// class vector bit positions
`define VCU_CLS_CFG    11   // vsetvl / vsetvli
`define VCU_CLS_OPIVX  10
`define VCU_CLS_OPIVI  9
`define VCU_CLS_OPIVV  8
`define VCU_CLS_OPMVX  7
`define VCU_CLS_OPMVV  6
`define VCU_CLS_LOAD   5
`define VCU_CLS_ILOAD  4
`define VCU_CLS_STORE  3
`define VCU_CLS_ISTORE 2

// edges a destination stays busy after its issue
`define VCU_DEP_DELAY  11

`endif
